// ==== vlog.f ====
+incdir+src
src/pru_pkg.sv
src/shape_cmd_if.sv
src/pru_preprocessing.sv
src/pru_palette.sv
src/pru_rasterizer.sv
src/pru_top.sv
verif/pru_checker.sv
verif/pru_tb.sv

// ==== Bender.yml ====
package:
  name: pru

sources:
  - include_dirs:
      - src
    files:
      - src/pru_pkg.sv
      - src/shape_cmd_if.sv
      - src/pru_preprocessing.sv
      - src/pru_palette.sv
      - src/pru_rasterizer.sv
      - src/pru_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/pru_checker.sv
      - verif/pru_tb.sv

// ==== verif/pru_tb.sv ====
`timescale 1ns/100ps
`include "pru_params.svh"

module pru_tb;

    localparam int N_CMDS      = 53;                  // Shape commands over all tests
    localparam int CYCLE_LIMIT = N_CMDS * 1200 + 1000;

    logic          clk;
    logic          rst_n;
    logic          write;
    logic [31:0]   data;
    logic [31:0]   bus_addr;
    logic          ack;
    logic          busy;
    logic          pixel_valid;
    logic [9:0]    pixel_x;
    logic [8:0]    pixel_y;
    pru_pkg::rgb_t pixel_rgb;

    logic [11:0] pal_model [4];                       // Expected palette contents
    int          cycles = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errs_before = 0;

    pru_top u_pru_top (.*);
    pru_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT never finished the tests", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Hold the write until acked, release on the next falling edge
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
        write    = 1'b1;
        bus_addr = addr;
        data     = wdata;
        u_checker.expect_ack();
        do begin
            @(posedge clk);
        end while (!ack);
        @(negedge clk);
        write = 1'b0;
    endtask

    // Outside the window, never acked, so held two cycles only
    task automatic stray_write();
        logic [23:0] hi;
        logic [7:0]  lo;
        hi = $urandom_range(1) ? 24'($urandom()) : (`PRU_BASE_HI ^ (24'd1 << $urandom_range(23)));
        if (hi == `PRU_BASE_HI) begin
            hi = ~hi;
        end
        lo = $urandom_range(1) ? 8'(`PRU_PAL0_OFS + 4 * $urandom_range(3)) : 8'($urandom());
        write    = 1'b1;
        bus_addr = {hi, lo};
        data     = $urandom();
        repeat (2) @(negedge clk);
        write = 1'b0;
    endtask

    task automatic pal_write(input int idx, input logic [11:0] rgb);
        logic [7:0] ofs;
        case (idx)
            0:       ofs = `PRU_PAL0_OFS;
            1:       ofs = `PRU_PAL1_OFS;
            2:       ofs = `PRU_PAL2_OFS;
            default: ofs = `PRU_PAL3_OFS;
        endcase
        pal_model[idx] = rgb;
        bus_write({`PRU_BASE_HI, ofs}, {20'($urandom()), rgb});  // Upper bits ignored
    endtask

    // Row-major expansion of one command with screen clipping
    task automatic model_shape(input int shape, col, row, idx, w, hr, sub);
        int          x0;
        int          x1;
        int          y0;
        int          y1;
        int          n;
        logic [11:0] rgb;
        rgb = sub ? 12'h000 : pal_model[idx];
        n   = 0;
        x0  = 0;
        x1  = -1;                                     // Reserved codes scan nothing
        y0  = row;
        y1  = row - 1;
        if (shape == 0) begin
            x0 = col;
            x1 = col + w - 1;
            y1 = row + hr - 1;
        end else if (shape == 1) begin
            x0 = col - hr;
            x1 = col + hr;
            y0 = row - hr;
            y1 = row + hr;
        end
        for (int y = y0; y <= y1; y++) begin
            for (int x = x0; x <= x1; x++) begin
                n++;                                  // One cycle per box position
                if (x >= 0 && x < `PRU_SCREEN_W && y >= 0 && y < `PRU_SCREEN_H &&
                    (shape == 0 || (x - col) * (x - col) + (y - row) * (y - row) <= hr * hr)) begin
                    u_checker.expect_pixel(x, y, rgb);
                end
            end
        end
        u_checker.expect_draw(n);
    endtask

    // Mid 1 puts a palette write between the words, mid 2 a stray write
    task automatic draw(input int shape, col, row, idx, w, hr, sub, mid);
        logic [31:0] w1;
        logic [31:0] w2;
        logic [7:0]  ofs;
        w1  = {9'($urandom()), 2'(shape), 2'(idx), 10'(col), 9'(row)};
        w2  = {12'($urandom()), 1'(sub), 10'(w), 9'(hr)};
        ofs = 8'($urandom());
        if (ofs inside {`PRU_PAL0_OFS, `PRU_PAL1_OFS, `PRU_PAL2_OFS, `PRU_PAL3_OFS}) begin
            ofs = 8'h00;                              // Keep shape words off the palette
        end
        bus_write({`PRU_BASE_HI, ofs}, w1);
        if (mid == 1) begin
            pal_write($urandom_range(3), 12'($urandom()));
        end else if (mid == 2) begin
            stray_write();
        end
        model_shape(shape, col, row, idx, w, hr, sub);
        bus_write({`PRU_BASE_HI, ofs}, w2);
    endtask

    // Often close to 0 or just past the far edge
    function automatic int near_edge(input int limit);
        case ($urandom_range(2))
            0:       return $urandom_range(15);
            1:       return limit - 24 + $urandom_range(32);
            default: return $urandom_range(limit - 1);
        endcase
    endfunction

    task automatic end_test(input string name);
        int errs;
        while (busy) @(negedge clk);
        @(posedge clk);
        @(negedge clk);
        errs = u_checker.errors - errs_before;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %-10s %s, %0d errors", name, (errs == 0) ? "passed" : "FAILED", errs);
        errs_before = u_checker.errors;
    endtask

    initial begin
        void'($urandom(32'ha3b1_c8b1));
        rst_n    = 1'b0;
        write    = 1'b0;
        data     = '0;
        bus_addr = '0;
        foreach (pal_model[i]) begin
            pal_model[i] = 12'h000;                   // Cleared by reset
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        draw(0, 300, 200, 2, 4, 3, 0, 0);             // Black before any palette write
        for (int i = 0; i < 4; i++) begin
            pal_write(i, 12'($urandom()));
        end
        for (int i = 0; i < 4; i++) begin
            draw(0, 100 + 40 * i, 100, i, 8, 6, 0, 0);
        end
        end_test("palette");

        draw(0, 50, 60, 1, 0, 5, 0, 0);               // Zero width
        draw(0, 70, 80, 3, 7, 0, 0, 0);               // Zero height
        for (int i = 0; i < 12; i++) begin
            draw(0, near_edge(`PRU_SCREEN_W), near_edge(`PRU_SCREEN_H), $urandom_range(3),
                 $urandom_range(32), $urandom_range(32), 0, 0);
        end
        end_test("rectangle");

        for (int i = 0; i < 14; i++) begin
            draw(1, near_edge(`PRU_SCREEN_W), near_edge(`PRU_SCREEN_H), $urandom_range(3),
                 $urandom_range(32), $urandom_range(16), 0, 0);
        end
        end_test("circle");

        for (int i = 0; i < 8; i++) begin
            draw($urandom_range(1), near_edge(`PRU_SCREEN_W), near_edge(`PRU_SCREEN_H),
                 $urandom_range(3), $urandom_range(1, 32), $urandom_range(1, 16), 1, 0);
        end
        end_test("subtract");

        draw(0, 200, 150, 0, 20, 10, 0, 1);
        pal_write(1, 12'($urandom()));                // Held while the draw runs
        draw(1, 400, 300, 1, 0, 9, 0, 1);
        draw(0, 630, 470, $urandom_range(3), 16, 16, 0, 0);
        draw(1, 5, 470, $urandom_range(3), 0, 12, 0, 0);
        end_test("backpress");

        for (int i = 0; i < 4; i++) begin
            repeat (3) stray_write();
            draw(0, near_edge(`PRU_SCREEN_W), near_edge(`PRU_SCREEN_H), $urandom_range(3),
                 $urandom_range(1, 32), $urandom_range(1, 32), 0, 2);
        end
        for (int i = 0; i < 4; i++) begin
            draw(2 + $urandom_range(1), 300, 200, $urandom_range(3), $urandom_range(32),
                 $urandom_range(32), $urandom_range(1), 0);
        end
        end_test("filter");

        u_checker.final_check();
        $display("tests run %0d, failed %0d, pixels checked %0d, errors %0d",
                 tests_run, tests_failed, u_checker.pixels_checked, u_checker.errors);
        if (u_checker.errors == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/pru_checker.sv ====
`timescale 1ns/100ps

module pru_checker (
    input logic          clk,
    input logic          rst_n,
    input logic          ack,
    input logic          busy,
    input logic          pixel_valid,
    input logic [9:0]    pixel_x,
    input logic [8:0]    pixel_y,
    input pru_pkg::rgb_t pixel_rgb
);

    logic [30:0] exp_q [$];            // {x, y, rgb} in scan order
    int          errors = 0;
    int          pixels_checked = 0;
    int          acks_seen = 0;
    int          acks_expected = 0;
    logic        busy_prev = 1'b0;
    logic        ack_pending = 1'b0;   // Window write held on the bus
    logic        launch_armed = 1'b0;  // Next ack is word 2 of a command
    int          launch_len = 0;       // Scan candidates of the armed command
    int          busy_left = 0;        // Expected busy cycles still to run

    task automatic expect_pixel(input int x, input int y, input logic [11:0] rgb);
        exp_q.push_back({x[9:0], y[8:0], rgb});
    endtask

    task automatic expect_ack();
        acks_expected++;
        ack_pending = 1'b1;
    endtask

    task automatic expect_draw(input int candidates);
        launch_armed = 1'b1;
        launch_len   = candidates;
    endtask

    task automatic compare(input string name, input int expv, input int got);
        if (expv != got) begin
            $display("MISMATCH time %0t %s expected 0x%0h actual 0x%0h",
                     $time, name, expv, got);
            errors++;
        end
    endtask

    task automatic check_pixel();
        logic [30:0] exp;
        pixels_checked++;
        if (exp_q.size() == 0) begin
            $display("Pixel strobe at (%0d,%0d) at time %0t where no pixel was expected",
                     pixel_x, pixel_y, $time);
            errors++;
        end else begin
            exp = exp_q.pop_front();
            compare("pixel_x", exp[30:21], pixel_x);
            compare("pixel_y", exp[20:12], pixel_y);
            compare("pixel_rgb", exp[11:0], pixel_rgb);
        end
    endtask

    // Sampled at the rising edge, before registers update
    always @(posedge clk) begin
        if (rst_n) begin
            compare("ack", ack_pending && (busy_left == 0), ack);   // Held off during a draw
            compare("busy", busy_left != 0, busy);
            if (ack) begin
                acks_seen++;
                ack_pending = 1'b0;
            end
            if (busy_left != 0) begin
                busy_left--;
            end
            if (ack && launch_armed) begin
                busy_left    = launch_len + 1;      // Start cycle plus one per candidate
                launch_armed = 1'b0;
            end
            if (pixel_valid) begin
                check_pixel();
            end
            if (busy_prev && !busy && exp_q.size() != 0) begin
                $display("Draw ended at time %0t with %0d expected pixels missing",
                         $time, exp_q.size());
                errors++;
                exp_q.delete();
            end
            busy_prev = busy;
        end else begin
            busy_prev = 1'b0;
        end
    end

    task automatic final_check();
        if (exp_q.size() != 0) begin
            $display("Run ended with %0d expected pixels never drawn", exp_q.size());
            errors++;
        end
        if (acks_seen != acks_expected) begin
            $display("DUT acknowledged %0d writes but %0d were expected",
                     acks_seen, acks_expected);
            errors++;
        end
    endtask

endmodule

// ==== src/pru_top.sv ====
`timescale 1ns/100ps

module pru_top (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          write,
    input  logic [31:0]   data,
    input  logic [31:0]   bus_addr,
    output logic          ack,
    output logic          busy,
    output logic          pixel_valid,
    output logic [9:0]    pixel_x,
    output logic [8:0]    pixel_y,
    output pru_pkg::rgb_t pixel_rgb
);

    logic          pal_we;
    logic [1:0]    pal_idx_w;
    pru_pkg::rgb_t pal_rgb_w;
    logic [1:0]    pal_idx_r;
    pru_pkg::rgb_t pal_rgb_r;

    shape_cmd_if u_cmd_if ();

    pru_preprocessing u_preprocessing (
        .clk      (clk),
        .rst_n    (rst_n),
        .write    (write),
        .data     (data),
        .bus_addr (bus_addr),
        .busy     (busy),
        .ack      (ack),
        .pal_we   (pal_we),
        .pal_idx  (pal_idx_w),
        .pal_rgb  (pal_rgb_w),
        .cmd      (u_cmd_if.src)
    );

    pru_palette u_palette (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (pal_we),
        .idx_w (pal_idx_w),
        .rgb_w (pal_rgb_w),
        .idx_r (pal_idx_r),
        .rgb_r (pal_rgb_r)
    );

    pru_rasterizer u_rasterizer (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (u_cmd_if.dst),
        .pal_rgb     (pal_rgb_r),
        .pal_idx     (pal_idx_r),
        .busy        (busy),
        .pixel_valid (pixel_valid),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_rgb   (pixel_rgb)
    );

endmodule

// ==== src/pru_rasterizer.sv ====
`timescale 1ns/100ps
`include "pru_params.svh"

module pru_rasterizer (
    input  logic          clk,
    input  logic          rst_n,
    shape_cmd_if.dst      cmd,
    input  pru_pkg::rgb_t pal_rgb,
    output logic [1:0]    pal_idx,
    output logic          busy,
    output logic          pixel_valid,
    output logic [9:0]    pixel_x,
    output logic [8:0]    pixel_y,
    output pru_pkg::rgb_t pixel_rgb
);

    // Scan state
    logic               running_q;
    logic signed [11:0] x_q;
    logic signed [10:0] y_q;

    // Latched command
    logic signed [11:0] x_min_q;
    logic signed [11:0] x_max_q;
    logic signed [10:0] y_max_q;
    logic signed [11:0] cx_q;
    logic signed [10:0] cy_q;
    logic [8:0]         r_q;
    pru_pkg::shape_e    shape_q;
    logic               subtract_q;
    logic [1:0]         colour_idx_q;

    // Box of the incoming command
    logic signed [11:0] col_s;
    logic signed [11:0] rad_x_s;
    logic signed [11:0] x_min_d;
    logic signed [11:0] x_max_d;
    logic signed [10:0] row_s;
    logic signed [10:0] rad_y_s;
    logic signed [10:0] y_min_d;
    logic signed [10:0] y_max_d;
    logic               draw_ok;

    // Coverage test
    logic signed [11:0] dx_full;
    logic signed [10:0] dy_full;
    logic [19:0]        dist_sq;
    logic [19:0]        rad_sq;
    logic               covered;
    logic               on_screen;

    // |v| fits 9 bits inside a circle box
    function automatic logic [17:0] square(input logic signed [9:0] v);
        logic [8:0] mag;
        mag = v[9] ? 9'(-v) : v[8:0];
        return mag * mag;
    endfunction

    always_comb begin
        col_s   = {2'b00, cmd.col};
        row_s   = {2'b00, cmd.row};
        rad_x_s = {3'b000, cmd.height_radius};
        rad_y_s = {2'b00, cmd.height_radius};
        x_min_d = col_s;
        x_max_d = col_s + $signed({2'b00, cmd.width}) - 12'sd1;
        y_min_d = row_s;
        y_max_d = row_s + rad_y_s - 11'sd1;
        draw_ok = (cmd.width != 10'd0) && (cmd.height_radius != 9'd0);
        if (cmd.shape == pru_pkg::shape_circle) begin
            x_min_d = col_s - rad_x_s;
            x_max_d = col_s + rad_x_s;
            y_min_d = row_s - rad_y_s;
            y_max_d = row_s + rad_y_s;
            draw_ok = 1'b1;                     // Radius 0 still gives the centre
        end else if (cmd.shape != pru_pkg::shape_rect) begin
            draw_ok = 1'b0;                     // Reserved codes
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running_q <= 1'b0;
            x_q       <= '0;
            y_q       <= '0;
        end else if (cmd.start) begin
            running_q <= draw_ok;
            x_q       <= x_min_d;
            y_q       <= y_min_d;
        end else if (running_q) begin
            if (x_q == x_max_q) begin
                x_q <= x_min_q;                 // Wrap to the next row
                if (y_q == y_max_q) begin
                    running_q <= 1'b0;
                end else begin
                    y_q <= y_q + 11'sd1;
                end
            end else begin
                x_q <= x_q + 12'sd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.start) begin
            x_min_q      <= x_min_d;
            x_max_q      <= x_max_d;
            y_max_q      <= y_max_d;
            cx_q         <= col_s;
            cy_q         <= row_s;
            r_q          <= cmd.height_radius;
            shape_q      <= cmd.shape;
            subtract_q   <= cmd.subtract;
            colour_idx_q <= cmd.colour_idx;
        end
    end

    assign dx_full = x_q - cx_q;
    assign dy_full = y_q - cy_q;
    assign dist_sq = {2'b00, square(dx_full[9:0])} + {2'b00, square(dy_full[9:0])};
    assign rad_sq  = {2'b00, square({1'b0, r_q})};

    // Only rectangles and circles ever run
    assign covered   = (shape_q == pru_pkg::shape_circle) ? (dist_sq <= rad_sq) : 1'b1;
    assign on_screen = (x_q >= 12'sd0) && (x_q < `PRU_SCREEN_W) &&
                       (y_q >= 11'sd0) && (y_q < `PRU_SCREEN_H);

    assign busy        = cmd.start || running_q;
    assign pixel_valid = running_q && covered && on_screen;
    assign pixel_x     = x_q[9:0];
    assign pixel_y     = y_q[8:0];
    assign pal_idx     = colour_idx_q;
    assign pixel_rgb   = subtract_q ? '0 : pal_rgb;   // Erase writes black

    // Scan counters stay inside the latched box
    a_scan_in_box: assert property (
        @(posedge clk) disable iff (!rst_n)
        running_q |-> (x_q >= x_min_q) && (x_q <= x_max_q) && (y_q <= y_max_q)
    ) else $error("scan left the shape box");

    // Circle offsets must survive the cut to 10 squarer bits
    a_offset_fits: assert property (
        @(posedge clk) disable iff (!rst_n)
        running_q && (shape_q == pru_pkg::shape_circle) |->
            (dx_full[11:9] inside {3'b000, 3'b111}) && (dy_full[10:9] inside {2'b00, 2'b11})
    ) else $error("circle offset too wide for the squarer");

endmodule

// ==== src/pru_palette.sv ====
`timescale 1ns/100ps

module pru_palette (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          we,
    input  logic [1:0]    idx_w,
    input  pru_pkg::rgb_t rgb_w,
    input  logic [1:0]    idx_r,
    output pru_pkg::rgb_t rgb_r
);

    pru_pkg::rgb_t pal_q [4];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                pal_q[i] <= '0;                 // All entries black
            end
        end else if (we) begin
            pal_q[idx_w] <= rgb_w;
        end
    end

    assign rgb_r = pal_q[idx_r];                // Combinational read

endmodule

// ==== src/pru_preprocessing.sv ====
`timescale 1ns/100ps
`include "pru_params.svh"

module pru_preprocessing (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          write,
    input  logic [31:0]   data,
    input  logic [31:0]   bus_addr,
    input  logic          busy,
    output logic          ack,
    output logic          pal_we,
    output logic [1:0]    pal_idx,
    output pru_pkg::rgb_t pal_rgb,
    shape_cmd_if.src      cmd
);

    typedef enum logic {
        st_idle,
        st_load_second
    } state_e;

    state_e             state_q;
    state_e             state_d;
    pru_pkg::cmd_word_u word;
    logic               in_window;
    logic               is_pal;
    logic               accept;
    logic               load1;
    logic               load2;

    assign word      = data;
    assign in_window = (bus_addr[31:8] == `PRU_BASE_HI);
    assign accept    = write && in_window && !busy;   // Held by the master until this rises
    assign ack       = accept;

    // Palette offsets inside the window
    always_comb begin
        is_pal  = 1'b1;
        pal_idx = 2'd0;
        case (bus_addr[7:0])
            `PRU_PAL0_OFS: pal_idx = 2'd0;
            `PRU_PAL1_OFS: pal_idx = 2'd1;
            `PRU_PAL2_OFS: pal_idx = 2'd2;
            `PRU_PAL3_OFS: pal_idx = 2'd3;
            default:       is_pal  = 1'b0;            // Any other offset is a shape word
        endcase
    end

    assign pal_we  = accept && is_pal;
    assign pal_rgb = data[11:0];

    // Palette writes never move the FSM
    always_comb begin
        state_d = state_q;
        load1   = 1'b0;
        load2   = 1'b0;
        if (accept && !is_pal) begin
            if (state_q == st_idle) begin
                load1   = 1'b1;
                state_d = st_load_second;
            end else begin
                load2   = 1'b1;
                state_d = st_idle;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= st_idle;
            cmd.start <= 1'b0;
        end else begin
            state_q   <= state_d;
            cmd.start <= load2;                       // Launch the cycle after word 2
        end
    end

    always_ff @(posedge clk) begin
        if (load1) begin
            cmd.row        <= word.word1.row;
            cmd.col        <= word.word1.col;
            cmd.colour_idx <= word.word1.colour_idx;
            cmd.shape      <= word.word1.shape;
        end
        if (load2) begin
            cmd.height_radius <= word.word2.height_radius;
            cmd.width         <= word.word2.width;
            cmd.subtract      <= word.word2.subtract;
        end
    end

    // Busy comes back from the rasterizer and must already cover the start cycle
    a_busy_on_start: assert property (
        @(posedge clk) disable iff (!rst_n) cmd.start |-> busy
    ) else $error("start pulse without busy from the rasterizer");

    // A refused window write stays on the bus unchanged until acked
    a_write_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        write && in_window && !ack |=> write && $stable(bus_addr) && $stable(data)
    ) else $error("window write dropped or changed before ack");

endmodule

// ==== src/shape_cmd_if.sv ====
`timescale 1ns/100ps

interface shape_cmd_if;
    logic            start;            // One-cycle launch pulse
    logic [9:0]      col;              // Box corner or circle centre
    logic [8:0]      row;
    logic [9:0]      width;
    logic [8:0]      height_radius;    // Rectangle height or circle radius
    pru_pkg::shape_e shape;
    logic [1:0]      colour_idx;       // Palette entry to draw with
    logic            subtract;         // Erase, draw black

    modport src (
        output start,
        output col,
        output row,
        output width,
        output height_radius,
        output shape,
        output colour_idx,
        output subtract
    );

    modport dst (
        input start,
        input col,
        input row,
        input width,
        input height_radius,
        input shape,
        input colour_idx,
        input subtract
    );
endinterface

// ==== src/pru_pkg.sv ====
package pru_pkg;

    typedef enum logic [1:0] {
        shape_rect   = 2'd0,           // Filled rectangle
        shape_circle = 2'd1,           // Filled circle
        shape_rsv2   = 2'd2,           // Reserved, draws nothing
        shape_rsv3   = 2'd3            // Reserved, draws nothing
    } shape_e;

    // First command word, position and colour
    typedef struct packed {
        logic [8:0]  unused;
        shape_e      shape;            // Bits 22:21
        logic [1:0]  colour_idx;       // Bits 20:19
        logic [9:0]  col;              // Bits 18:9
        logic [8:0]  row;              // Bits 8:0
    } cmd_word1_s;

    // Second command word, size and erase flag
    typedef struct packed {
        logic [11:0] unused;
        logic        subtract;         // Bit 19
        logic [9:0]  width;            // Bits 18:9
        logic [8:0]  height_radius;    // Bits 8:0
    } cmd_word2_s;

    // One bus word, read as word 1 or word 2 depending on FSM state
    typedef union packed {
        cmd_word1_s word1;
        cmd_word2_s word2;
    } cmd_word_u;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

endpackage

// ==== src/pru_params.svh ====
`ifndef PRU_PARAMS_SVH
`define PRU_PARAMS_SVH

// Bus window at 0x4000_0100, 256 bytes
`define PRU_BASE_HI     24'h400001   // Upper address bits of the window

// Low-byte offsets of the palette entries
`define PRU_PAL0_OFS    8'h0C        // Palette entry 0
`define PRU_PAL1_OFS    8'h10        // Palette entry 1
`define PRU_PAL2_OFS    8'h14        // Palette entry 2
`define PRU_PAL3_OFS    8'h18        // Palette entry 3

// Visible area. The scan clips candidates to 0 <= x < W and 0 <= y < H
`define PRU_SCREEN_W    640          // Columns
`define PRU_SCREEN_H    480          // Rows

`endif
